// ==== hdl/rr_arbiter.sv ====
module rr_arbiter #(
    parameter int unsigned  N     = 2,
    localparam int unsigned IDX_W = (N > 1) ? $clog2(N) : 1
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic [N-1:0]     req_i,
    output logic [N-1:0]     gnt_o,
    output logic [IDX_W-1:0] idx_o
);

    // Requester that has the highest priority in the current cycle
    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] ptr_d;

    // Scan the requesters starting at the pointer and wrap around
    // The first active one wins, so the grant is purely combinational
    always_comb begin
        logic        found;
        int unsigned cand;
        found = 1'b0;
        cand  = 0;
        gnt_o = '0;
        idx_o = '0;
        for (int unsigned i = 0; i < N; i++) begin
            cand = (ptr_q + i) % N;
            if (!found && req_i[cand]) begin
                found       = 1'b1;
                gnt_o[cand] = 1'b1;
                idx_o       = IDX_W'(cand);
            end
        end
    end

    // Next priority goes to the requester right after the winner
    assign ptr_d = (idx_o == IDX_W'(N - 1)) ? '0 : idx_o + 1'b1;

    // Any request means a grant was given this cycle, so the pointer moves on
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (|req_i) begin
            ptr_q <= ptr_d;
        end
    end

endmodule

// ==== hdl/soc_interconnect.sv ====
module soc_interconnect #(
    parameter int unsigned NR_MASTERS = 2,
    parameter int unsigned NR_BANKS   = 4,
    parameter int unsigned BANK_WORDS = 64,
    // Interleaved region, NR_BANKS x BANK_WORDS words
    parameter soc_interconnect_pkg::addr_rule_t INTLVD_RULE = '{
        start_addr: 32'h1C00_0000,
        end_addr:   32'h1C00_0000 + NR_BANKS * BANK_WORDS * soc_interconnect_pkg::BE_WIDTH
    },
    // Contiguous region, a single bank of BANK_WORDS words
    parameter soc_interconnect_pkg::addr_rule_t CONTIG_RULE = '{
        start_addr: 32'h1C01_0000,
        end_addr:   32'h1C01_0000 + BANK_WORDS * soc_interconnect_pkg::BE_WIDTH
    }
) (
    input  logic                                             clk_i,
    input  logic                                             arst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t [NR_MASTERS-1:0] mst_req_i,
    output soc_interconnect_pkg::tcdm_rsp_t [NR_MASTERS-1:0] mst_rsp_o
);

    // Demux outputs towards the two crossbars, one per master
    soc_interconnect_pkg::tcdm_req_t [NR_MASTERS-1:0] intlvd_req;
    soc_interconnect_pkg::tcdm_rsp_t [NR_MASTERS-1:0] intlvd_rsp;
    soc_interconnect_pkg::tcdm_req_t [NR_MASTERS-1:0] contig_req;
    soc_interconnect_pkg::tcdm_rsp_t [NR_MASTERS-1:0] contig_rsp;

    // Crossbar to memory bank links
    soc_interconnect_pkg::tcdm_req_t [NR_BANKS-1:0]   bank_req;
    soc_interconnect_pkg::tcdm_rsp_t [NR_BANKS-1:0]   bank_rsp;
    soc_interconnect_pkg::tcdm_req_t [0:0]            contig_bank_req;
    soc_interconnect_pkg::tcdm_rsp_t [0:0]            contig_bank_rsp;

    ////////////////////////////////////////
    // Address demultiplexers
    ////////////////////////////////////////

    // Each master decides locally which region it talks to
    // Unmapped accesses never leave the demux
    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_demux
        tcdm_addr_demux #(
            .INTLVD_RULE (INTLVD_RULE),
            .CONTIG_RULE (CONTIG_RULE)
        ) u_demux (
            .clk_i        (clk_i),
            .arst_n_i     (arst_n_i),
            .mst_req_i    (mst_req_i[m]),
            .mst_rsp_o    (mst_rsp_o[m]),
            .intlvd_req_o (intlvd_req[m]),
            .intlvd_rsp_i (intlvd_rsp[m]),
            .contig_req_o (contig_req[m]),
            .contig_rsp_i (contig_rsp[m])
        );
    end

    ////////////////////////////////////////
    // Interleaved region
    ////////////////////////////////////////

    // Consecutive words land in consecutive banks
    tcdm_crossbar #(
        .NR_MASTERS (NR_MASTERS),
        .NR_TARGETS (NR_BANKS),
        .BASE_ADDR  (INTLVD_RULE.start_addr)
    ) u_intlvd_xbar (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .mst_req_i (intlvd_req),
        .mst_rsp_o (intlvd_rsp),
        .tgt_req_o (bank_req),
        .tgt_rsp_i (bank_rsp)
    );

    for (genvar b = 0; b < NR_BANKS; b++) begin : gen_intlvd_bank
        tcdm_sram_bank #(
            .WORDS (BANK_WORDS)
        ) u_bank (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (bank_req[b]),
            .rsp_o    (bank_rsp[b])
        );
    end

    ////////////////////////////////////////
    // Contiguous region
    ////////////////////////////////////////

    // Same crossbar with a single target, so it only arbitrates
    tcdm_crossbar #(
        .NR_MASTERS (NR_MASTERS),
        .NR_TARGETS (1),
        .BASE_ADDR  (CONTIG_RULE.start_addr)
    ) u_contig_xbar (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .mst_req_i (contig_req),
        .mst_rsp_o (contig_rsp),
        .tgt_req_o (contig_bank_req),
        .tgt_rsp_i (contig_bank_rsp)
    );

    tcdm_sram_bank #(
        .WORDS (BANK_WORDS)
    ) u_contig_bank (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (contig_bank_req[0]),
        .rsp_o    (contig_bank_rsp[0])
    );

endmodule

// ==== hdl/soc_interconnect_pkg.sv ====
package soc_interconnect_pkg;

    ////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////

    // Byte address width of every master port
    localparam int unsigned ADDR_WIDTH = 32;
    // Data word width and also the size of one memory word
    localparam int unsigned DATA_WIDTH = 32;
    // One byte enable per data byte
    localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [BE_WIDTH-1:0]   be_t;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////

    // An address hits a rule when start_addr <= addr < end_addr
    typedef struct packed {
        addr_t start_addr;
        addr_t end_addr;
    } addr_rule_t;

    ////////////////////////////////////////
    // TCDM request and response
    ////////////////////////////////////////

    // Request side where wen is high for a read and low for a write
    typedef struct packed {
        logic  req;
        addr_t addr;
        logic  wen;
        be_t   be;
        data_t wdata;
    } tcdm_req_t;

    // Response side where gnt comes in the same cycle and the r_* fields one cycle later
    typedef struct packed {
        logic  gnt;
        logic  r_valid;
        logic  r_opc;
        data_t r_rdata;
    } tcdm_rsp_t;

    // Read data returned for accesses that hit no address rule
    localparam data_t ERROR_RESPONSE = 32'hBADACCE5;

endpackage

// ==== hdl/tcdm_addr_demux.sv ====
module tcdm_addr_demux #(
    parameter soc_interconnect_pkg::addr_rule_t INTLVD_RULE = '0,
    parameter soc_interconnect_pkg::addr_rule_t CONTIG_RULE = '0
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // Master side
    input  soc_interconnect_pkg::tcdm_req_t mst_req_i,
    output soc_interconnect_pkg::tcdm_rsp_t mst_rsp_o,
    // Towards the interleaved crossbar
    output soc_interconnect_pkg::tcdm_req_t intlvd_req_o,
    input  soc_interconnect_pkg::tcdm_rsp_t intlvd_rsp_i,
    // Towards the contiguous crossbar
    output soc_interconnect_pkg::tcdm_req_t contig_req_o,
    input  soc_interconnect_pkg::tcdm_rsp_t contig_rsp_i
);

    ////////////////////////////////////////
    // Address decoding
    ////////////////////////////////////////

    logic hit_intlvd;
    logic hit_contig;
    logic sel_intlvd;
    logic sel_contig;
    logic sel_err;

    assign hit_intlvd = (mst_req_i.addr >= INTLVD_RULE.start_addr) &&
                        (mst_req_i.addr <  INTLVD_RULE.end_addr);
    assign hit_contig = (mst_req_i.addr >= CONTIG_RULE.start_addr) &&
                        (mst_req_i.addr <  CONTIG_RULE.end_addr);

    // The interleaved rule takes precedence if the rules ever overlap
    assign sel_intlvd = hit_intlvd;
    assign sel_contig = !hit_intlvd && hit_contig;
    // Everything else ends up at the error responder
    assign sel_err    = !hit_intlvd && !hit_contig;

    ////////////////////////////////////////
    // Request routing
    ////////////////////////////////////////

    // Request going to the built-in error responder
    soc_interconnect_pkg::tcdm_req_t err_req;
    soc_interconnect_pkg::tcdm_rsp_t err_rsp;

    // All payload fields are fanned out unchanged, only req is steered
    // Exactly one of the three paths sees req for a given access
    always_comb begin
        intlvd_req_o     = mst_req_i;
        contig_req_o     = mst_req_i;
        err_req          = mst_req_i;
        intlvd_req_o.req = mst_req_i.req && sel_intlvd;
        contig_req_o.req = mst_req_i.req && sel_contig;
        err_req.req      = mst_req_i.req && sel_err;
    end

    ////////////////////////////////////////
    // Error responder
    ////////////////////////////////////////

    logic err_valid_q;
    logic err_read_q;

    // The responder never stalls, so every request is granted at once
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_valid_q <= 1'b0;
        end else begin
            err_valid_q <= err_req.req;
        end
    end

    // Remember the access type for the response in the next cycle
    always_ff @(posedge clk_i) begin
        if (err_req.req) begin
            err_read_q <= err_req.wen;
        end
    end

    // The error flag is raised together with r_valid for reads and writes alike
    always_comb begin
        err_rsp.gnt     = err_req.req;
        err_rsp.r_valid = err_valid_q;
        err_rsp.r_opc   = err_valid_q;
        err_rsp.r_rdata = err_read_q ? soc_interconnect_pkg::ERROR_RESPONSE : '0;
    end

    ////////////////////////////////////////
    // Response merging
    ////////////////////////////////////////

    // Only the selected path can grant, so the grants are simply ORed
    // Responses come one cycle after a grant and one access is granted per cycle,
    // so at most one source is valid at any time
    always_comb begin
        mst_rsp_o.gnt     = intlvd_rsp_i.gnt || contig_rsp_i.gnt || err_rsp.gnt;
        mst_rsp_o.r_valid = 1'b0;
        mst_rsp_o.r_opc   = 1'b0;
        mst_rsp_o.r_rdata = '0;
        if (intlvd_rsp_i.r_valid) begin
            mst_rsp_o.r_valid = 1'b1;
            mst_rsp_o.r_opc   = intlvd_rsp_i.r_opc;
            mst_rsp_o.r_rdata = intlvd_rsp_i.r_rdata;
        end else if (contig_rsp_i.r_valid) begin
            mst_rsp_o.r_valid = 1'b1;
            mst_rsp_o.r_opc   = contig_rsp_i.r_opc;
            mst_rsp_o.r_rdata = contig_rsp_i.r_rdata;
        end else if (err_rsp.r_valid) begin
            mst_rsp_o.r_valid = 1'b1;
            mst_rsp_o.r_opc   = err_rsp.r_opc;
            mst_rsp_o.r_rdata = err_rsp.r_rdata;
        end
    end

endmodule

// ==== hdl/tcdm_crossbar.sv ====
module tcdm_crossbar #(
    parameter int unsigned                 NR_MASTERS = 2,
    parameter int unsigned                 NR_TARGETS = 4,
    parameter soc_interconnect_pkg::addr_t BASE_ADDR  = '0
) (
    input  logic                                             clk_i,
    input  logic                                             arst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t [NR_MASTERS-1:0] mst_req_i,
    output soc_interconnect_pkg::tcdm_rsp_t [NR_MASTERS-1:0] mst_rsp_o,
    output soc_interconnect_pkg::tcdm_req_t [NR_TARGETS-1:0] tgt_req_o,
    input  soc_interconnect_pkg::tcdm_rsp_t [NR_TARGETS-1:0] tgt_rsp_i
);

    // Width of a master index and of a target select field
    localparam int unsigned IDX_W      = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;
    localparam int unsigned SEL_W      = (NR_TARGETS > 1) ? $clog2(NR_TARGETS) : 1;
    // Bits dropped from the word address once the target is known
    localparam int unsigned SEL_SHIFT  = (NR_TARGETS > 1) ? $clog2(NR_TARGETS) : 0;
    // Byte offset bits inside one word
    localparam int unsigned BYTE_SHIFT = $clog2(soc_interconnect_pkg::BE_WIDTH);

    ////////////////////////////////////////
    // Target selection
    ////////////////////////////////////////

    logic [SEL_W-1:0]            tgt_sel    [NR_MASTERS];
    soc_interconnect_pkg::addr_t local_addr [NR_MASTERS];

    // The low bits of the region offset in words pick the bank and the rest
    // is the word index inside that bank
    always_comb begin
        soc_interconnect_pkg::addr_t word;
        word = '0;
        for (int unsigned m = 0; m < NR_MASTERS; m++) begin
            word          = (mst_req_i[m].addr - BASE_ADDR) >> BYTE_SHIFT;
            tgt_sel[m]    = (NR_TARGETS > 1) ? word[SEL_W-1:0] : '0;
            local_addr[m] = word >> SEL_SHIFT;
        end
    end

    ////////////////////////////////////////
    // Per target arbitration
    ////////////////////////////////////////

    logic [NR_MASTERS-1:0] arb_req [NR_TARGETS];
    logic [NR_MASTERS-1:0] arb_gnt [NR_TARGETS];
    logic [IDX_W-1:0]      arb_idx [NR_TARGETS];
    // The winner of the previous cycle per target steers the response
    logic [IDX_W-1:0]      winner_q [NR_TARGETS];

    // A master competes only for the target its address points to
    always_comb begin
        for (int unsigned t = 0; t < NR_TARGETS; t++) begin
            for (int unsigned m = 0; m < NR_MASTERS; m++) begin
                arb_req[t][m] = mst_req_i[m].req && (tgt_sel[m] == SEL_W'(t));
            end
        end
    end

    for (genvar t = 0; t < NR_TARGETS; t++) begin : gen_target
        rr_arbiter #(
            .N (NR_MASTERS)
        ) u_arbiter (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (arb_req[t]),
            .gnt_o    (arb_gnt[t]),
            .idx_o    (arb_idx[t])
        );
    end

    // The winning request goes out with its address already made local
    always_comb begin
        for (int unsigned t = 0; t < NR_TARGETS; t++) begin
            tgt_req_o[t]      = mst_req_i[arb_idx[t]];
            tgt_req_o[t].addr = local_addr[arb_idx[t]];
            tgt_req_o[t].req  = |arb_req[t];
        end
    end

    // Every target answers exactly one cycle after it was given a request
    always_ff @(posedge clk_i) begin
        for (int unsigned t = 0; t < NR_TARGETS; t++) begin
            if (|arb_req[t]) begin
                winner_q[t] <= arb_idx[t];
            end
        end
    end

    ////////////////////////////////////////
    // Grant and response return
    ////////////////////////////////////////

    // A master wins at most one target per cycle, since it sends one request
    always_comb begin
        for (int unsigned m = 0; m < NR_MASTERS; m++) begin
            mst_rsp_o[m] = '0;
            for (int unsigned t = 0; t < NR_TARGETS; t++) begin
                if (arb_gnt[t][m]) begin
                    mst_rsp_o[m].gnt = 1'b1;
                end
                if (tgt_rsp_i[t].r_valid && (winner_q[t] == IDX_W'(m))) begin
                    mst_rsp_o[m].r_valid = 1'b1;
                    mst_rsp_o[m].r_opc   = tgt_rsp_i[t].r_opc;
                    mst_rsp_o[m].r_rdata = tgt_rsp_i[t].r_rdata;
                end
            end
        end
    end

endmodule

// ==== hdl/tcdm_sram_bank.sv ====
module tcdm_sram_bank #(
    parameter int unsigned WORDS = 64
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t req_i,
    output soc_interconnect_pkg::tcdm_rsp_t rsp_o
);

    localparam int unsigned IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam int unsigned NB    = soc_interconnect_pkg::BE_WIDTH;

    // The crossbar has already reduced addr to the local word index
    logic [IDX_W-1:0]            word_idx;
    soc_interconnect_pkg::data_t mem [WORDS];
    soc_interconnect_pkg::data_t rdata_q;
    logic                        valid_q;

    assign word_idx = req_i.addr[IDX_W-1:0];

    // The single port writes the enabled bytes or reads the whole word
    // On a write the old word is read out, which nobody looks at
    always_ff @(posedge clk_i) begin
        if (req_i.req) begin
            if (!req_i.wen) begin
                for (int unsigned b = 0; b < NB; b++) begin
                    if (req_i.be[b]) begin
                        mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[word_idx];
        end
    end

    // One response per accepted request, writes included
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.req;
        end
    end

    // gnt is generated by the crossbar and the bank never signals an error
    always_comb begin
        rsp_o.gnt     = 1'b0;
        rsp_o.r_valid = valid_q;
        rsp_o.r_opc   = 1'b0;
        rsp_o.r_rdata = rdata_q;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_soc_interconnect -o tb_sim > sim.log 2>&1 \
    && ./obj_dir/tb_sim >> sim.log 2>&1
grep -qx '\*\* PASS \*\*' sim.log \
    && echo "Simulation passed, see sim.log" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tests/soc_interconnect_assertions.sv ====
module soc_interconnect_assertions #(
    parameter int unsigned NR_MASTERS = 2
) (
    input logic                                             clk_i,
    input logic                                             arst_n_i,
    input soc_interconnect_pkg::tcdm_req_t [NR_MASTERS-1:0] mst_req_i,
    input soc_interconnect_pkg::tcdm_rsp_t [NR_MASTERS-1:0] mst_rsp_i
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////
    // TCDM handshake rules per master
    ////////////////////////////////////////

    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_master
        // A grant is only ever given to a raised request
        gnt_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            mst_rsp_i[m].gnt |-> mst_req_i[m].req)
            else $error("Master %0d was granted without a request", m);

        // Every target answers exactly one cycle after the grant
        valid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            $past(mst_rsp_i[m].gnt) |-> mst_rsp_i[m].r_valid)
            else $error("Master %0d got no response one cycle after a grant", m);

        // A response without a grant in the cycle before is a stray one
        no_stray_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            mst_rsp_i[m].r_valid |-> $past(mst_rsp_i[m].gnt))
            else $error("Master %0d got a response that no grant asked for", m);

        // The error flag only means something together with r_valid
        opc_with_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            mst_rsp_i[m].r_opc |-> mst_rsp_i[m].r_valid)
            else $error("Master %0d saw r_opc outside a response", m);
    end

endmodule

bind soc_interconnect soc_interconnect_assertions #(
    .NR_MASTERS (NR_MASTERS)
) u_assertions (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .mst_req_i (mst_req_i),
    .mst_rsp_i (mst_rsp_o)
);

// ==== tests/tb_soc_interconnect.sv ====
module tb_soc_interconnect;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned NR_MASTERS = 2;
    localparam int unsigned NR_BANKS   = 4;
    localparam int unsigned BANK_WORDS = 64;
    // Transactions issued by each master
    localparam int unsigned NR_TRANS   = 400;
    // Two contended cycles per transaction at most, plus idle cycles and margin
    localparam int unsigned TIMEOUT_CYCLES = NR_MASTERS * NR_TRANS * 5;

    // Address map of the two regions and the word for unmapped reads
    localparam soc_interconnect_pkg::addr_t INTLVD_BASE = 32'h1C00_0000;
    localparam soc_interconnect_pkg::addr_t INTLVD_END  = INTLVD_BASE + NR_BANKS * BANK_WORDS * 4;
    localparam soc_interconnect_pkg::addr_t CONTIG_BASE = 32'h1C01_0000;
    localparam soc_interconnect_pkg::addr_t CONTIG_END  = CONTIG_BASE + BANK_WORDS * 4;
    localparam soc_interconnect_pkg::data_t ERROR_WORD  = 32'hBADACCE5;

    logic                                             clk;
    logic                                             arst_n;
    soc_interconnect_pkg::tcdm_req_t [NR_MASTERS-1:0] mst_req;
    soc_interconnect_pkg::tcdm_rsp_t [NR_MASTERS-1:0] mst_rsp;

    integer      seed;
    int unsigned cycle_cnt = 0;
    int unsigned issued   [NR_MASTERS];
    logic        last_gnt [NR_MASTERS];
    // Response each master must see in the next cycle
    logic                        pend_valid [NR_MASTERS];
    logic                        pend_opc   [NR_MASTERS];
    soc_interconnect_pkg::data_t pend_data  [NR_MASTERS];
    soc_interconnect_pkg::data_t pend_mask  [NR_MASTERS];
    string                       pend_name  [NR_MASTERS];
    // Reference memory keyed by word aligned byte address
    soc_interconnect_pkg::data_t model_word  [soc_interconnect_pkg::addr_t];
    soc_interconnect_pkg::be_t   model_known [soc_interconnect_pkg::addr_t];
    // Target and winner of the last contended cycle
    int prev_tgt;
    int prev_winner;

    soc_interconnect #(
        .NR_MASTERS (NR_MASTERS),
        .NR_BANKS   (NR_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) u_dut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .mst_req_i (mst_req),
        .mst_rsp_o (mst_rsp)
    );

    always #50 clk = ~clk;

    // Ends the run if the masters get stuck
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the masters did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Arbitration target of an address where NR_BANKS stands for the contiguous bank
    function automatic int target_of(soc_interconnect_pkg::addr_t addr);
        if (addr >= INTLVD_BASE && addr < INTLVD_END) begin
            return int'(((addr - INTLVD_BASE) >> 2) % NR_BANKS);
        end
        if (addr >= CONTIG_BASE && addr < CONTIG_END) begin
            return NR_BANKS;
        end
        return -1;
    endfunction

    function automatic soc_interconnect_pkg::data_t byte_mask(soc_interconnect_pkg::be_t be);
        soc_interconnect_pkg::data_t mask;
        mask = '0;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{be[b]}};
        end
        return mask;
    endfunction

    // Small address pools so that banks collide and words are reused
    function automatic soc_interconnect_pkg::tcdm_req_t random_request();
        soc_interconnect_pkg::tcdm_req_t r;
        int unsigned                     kind;
        kind  = rand_below(8);
        r     = '0;
        r.req = 1'b1;
        if (kind < 5) begin
            r.addr = INTLVD_BASE + 4 * rand_below(16);
        end else if (kind < 7) begin
            r.addr = CONTIG_BASE + 4 * rand_below(8);
        end else begin
            case (rand_below(4))
                0:       r.addr = INTLVD_END;
                1:       r.addr = CONTIG_END;
                2:       r.addr = INTLVD_BASE - 4;
                default: r.addr = 32'h0000_2000;
            endcase
        end
        r.wen   = rand_below(2) == 1;
        r.be    = 4'(rand_below(16));
        r.wdata = $random(seed);
        return r;
    endfunction

    function automatic bit busy();
        for (int m = 0; m < NR_MASTERS; m++) begin
            if (issued[m] < NR_TRANS || mst_req[m].req || pend_valid[m]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_rdata(string name, soc_interconnect_pkg::data_t exp,
                               soc_interconnect_pkg::data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s rdata: expected %h, actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_opc(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[ERROR] %s r_opc: expected %b, actual %b", name, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_valid(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[ERROR] %s r_valid: expected %b, actual %b", name, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus, checks and model update
    ////////////////////////////////////////

    // A request is held until granted, then a new one may follow at once
    task automatic drive_requests();
        for (int m = 0; m < NR_MASTERS; m++) begin
            if (!mst_req[m].req || last_gnt[m]) begin
                if (issued[m] < NR_TRANS && rand_below(8) != 0) begin
                    mst_req[m] = random_request();
                    issued[m]++;
                end else begin
                    mst_req[m] = '0;
                end
            end
        end
    endtask

    // The responses now visible belong to the grants of the previous cycle
    task automatic check_responses();
        for (int m = 0; m < NR_MASTERS; m++) begin
            check_valid(pend_name[m], pend_valid[m], mst_rsp[m].r_valid);
            if (pend_valid[m]) begin
                check_opc(pend_name[m], pend_opc[m], mst_rsp[m].r_opc);
                check_rdata(pend_name[m], pend_data[m] & pend_mask[m],
                            mst_rsp[m].r_rdata & pend_mask[m]);
            end
        end
    endtask

    // Grant rules first, then the model follows the grants in order
    task automatic apply_grants();
        int                              tgt [NR_MASTERS];
        int                              win;
        soc_interconnect_pkg::tcdm_req_t r;
        soc_interconnect_pkg::addr_t     key;
        soc_interconnect_pkg::data_t     wmask;
        for (int m = 0; m < NR_MASTERS; m++) begin
            tgt[m] = mst_req[m].req ? target_of(mst_req[m].addr) : -2;
        end
        // Same target in the same cycle means only one can win
        if (tgt[0] >= 0 && tgt[0] == tgt[1]) begin
            if (mst_rsp[0].gnt === mst_rsp[1].gnt) begin
                report_failure($sformatf("Target %0d: not exactly one grant under contention",
                                         tgt[0]));
            end
            win = mst_rsp[1].gnt ? 1 : 0;
            if (tgt[0] == prev_tgt && win == prev_winner) begin
                report_failure($sformatf("Target %0d: master %0d won twice in a row", tgt[0], win));
            end
            prev_tgt    = tgt[0];
            prev_winner = win;
        end else begin
            for (int m = 0; m < NR_MASTERS; m++) begin
                if (mst_rsp[m].gnt !== mst_req[m].req) begin
                    report_failure($sformatf("Master %0d: grant %b for an uncontended req %b",
                                             m, mst_rsp[m].gnt, mst_req[m].req));
                end
            end
            prev_tgt = -1;
        end
        for (int m = 0; m < NR_MASTERS; m++) begin
            last_gnt[m]   = mst_rsp[m].gnt;
            pend_valid[m] = mst_rsp[m].gnt;
            pend_name[m]  = $sformatf("master %0d idle", m);
            if (mst_rsp[m].gnt) begin
                r            = mst_req[m];
                key          = {r.addr[31:2], 2'b00};
                pend_name[m] = $sformatf("master %0d %s at %h", m, r.wen ? "read" : "write", r.addr);
                if (target_of(r.addr) < 0) begin
                    // Unmapped accesses leave the memory alone and always flag an error
                    pend_opc[m]  = 1'b1;
                    pend_data[m] = ERROR_WORD;
                    pend_mask[m] = r.wen ? '1 : '0;
                end else begin
                    pend_opc[m] = 1'b0;
                    if (!model_word.exists(key)) begin
                        model_word[key]  = '0;
                        model_known[key] = '0;
                    end
                    if (r.wen) begin
                        // Bytes never written hold unknown data and are not compared
                        pend_data[m] = model_word[key];
                        pend_mask[m] = byte_mask(model_known[key]);
                    end else begin
                        wmask            = byte_mask(r.be);
                        model_word[key]  = (model_word[key] & ~wmask) | (r.wdata & wmask);
                        model_known[key] = model_known[key] | r.be;
                        pend_data[m]     = '0;
                        pend_mask[m]     = '0;
                    end
                end
            end
        end
    endtask

    initial begin
        seed        = 32'hd45b;
        clk         = 1'b0;
        arst_n      = 1'b0;
        mst_req     = '0;
        prev_tgt    = -1;
        prev_winner = 0;
        for (int m = 0; m < NR_MASTERS; m++) begin
            issued[m]     = 0;
            last_gnt[m]   = 1'b0;
            pend_valid[m] = 1'b0;
            pend_opc[m]   = 1'b0;
            pend_data[m]  = '0;
            pend_mask[m]  = '0;
            pend_name[m]  = $sformatf("master %0d after reset", m);
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // Drive after the edge, sample at the falling edge where all is settled
        while (busy()) begin
            drive_requests();
            @(negedge clk);
            check_responses();
            apply_grants();
            @(posedge clk);
            #1;
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/soc_interconnect_pkg.sv
hdl/rr_arbiter.sv
hdl/tcdm_addr_demux.sv
hdl/tcdm_crossbar.sv
hdl/tcdm_sram_bank.sv
hdl/soc_interconnect.sv
tests/soc_interconnect_assertions.sv
tests/tb_soc_interconnect.sv
